// File: hw/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// ********************
// Datapath sizing
// ********************

// Machine word
`define CPU_DATA_W 32

// General purpose registers R0..R15
`define CPU_NUM_REGS 16

// ********************
// Queue sizing
// ********************

// Input FIFO entries, also the sender's initial credits
`define CPU_INSTR_DEPTH 4

// Result FIFO entries
`define CPU_RESULT_DEPTH 4

`endif

// File: hw/immCpuPkg.sv
`include "cpu_config.svh"

package immCpuPkg;

        localparam int regIdxW = $clog2(`CPU_NUM_REGS);
        localparam int cW      = 19;                    // Immediate field width

        typedef logic [`CPU_DATA_W-1:0] wordT;
        typedef logic [regIdxW-1:0]     regIdxT;

        // ********************
        // Instruction format
        // ********************

        typedef enum logic [4:0] {
                ldi  = 5'd5,
                addi = 5'd6,
                andi = 5'd7,
                ori  = 5'd8
        } opcodeE;

        typedef struct packed {
                opcodeE        opcode;                  // Bits 31..27
                regIdxT        ra;                      // Bits 26..23
                regIdxT        rb;                      // Bits 22..19
                logic [cW-1:0] c;                       // Bits 18..0
        } instrT;

        // ********************
        // Stage records
        // ********************

        typedef struct packed {
                logic   valid;
                opcodeE opcode;
                regIdxT ra;                             // Destination
                wordT   opB;
                wordT   cExt;                           // Sign-extended C
                logic   illegal;
        } decodedOpT;

        typedef struct packed {
                logic   valid;
                logic   writesReg;
                regIdxT idx;
                wordT   value;
        } fwdT;

        typedef struct packed {
                regIdxT dest;
                wordT   value;
                logic   illegal;
        } resultT;

endpackage

// File: hw/creditFifo.sv
`timescale 1ns/1ps

module creditFifo #(
        parameter type payloadT = logic,
        parameter int  depth    = 4,
        localparam int ptrW     = (depth > 1) ? $clog2(depth) : 1,
        localparam int countW   = $clog2(depth + 1)
) (
        input  logic              Clock,
        input  logic              arstN,
        input  logic              pushValid,
        input  payloadT           pushData,
        input  logic              popReady,
        output logic              popValid,
        output payloadT           popData,
        output logic              creditReturn,
        output logic [countW-1:0] freeCount
);

        payloadT           mem [depth];
        logic [ptrW-1:0]   wrPtr;
        logic [ptrW-1:0]   rdPtr;
        logic [countW-1:0] count;
        logic              doPush;
        logic              doPop;

        function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
                if (ptr == ptrW'(depth - 1)) begin
                        return '0;
                end
                return ptr + 1'b1;
        endfunction

        assign popValid  = (count != '0);
        assign popData   = mem[rdPtr];
        assign freeCount = countW'(depth) - count;
        assign doPop     = popValid && popReady;
        assign doPush    = pushValid && ((freeCount != '0) || doPop);   // Full push is dropped

        always_ff @(posedge Clock) begin
                if (doPush) begin
                        mem[wrPtr] <= pushData;
                end
        end

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        wrPtr        <= '0;
                        rdPtr        <= '0;
                        count        <= '0;
                        creditReturn <= 1'b0;
                end else begin
                        if (doPush) begin
                                wrPtr <= nextPtr(wrPtr);
                        end
                        if (doPop) begin
                                rdPtr <= nextPtr(rdPtr);
                        end
                        count        <= count + countW'(doPush) - countW'(doPop);
                        creditReturn <= doPop;                  // One credit per entry leaving
                end
        end

endmodule

// File: hw/regFile.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module regFile
        import immCpuPkg::*;
(
        input  logic   Clock,
        input  logic   arstN,
        input  regIdxT readIdx,
        output wordT   readData,
        input  logic   writeEn,
        input  regIdxT writeIdx,
        input  wordT   writeData
);

        wordT regs [`CPU_NUM_REGS];

        // ********************
        // Read port
        // ********************

        // R0 is an ordinary register here; decode applies the ldi rule
        assign readData = regs[readIdx];

        // ********************
        // Write port
        // ********************

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                                regs[i] <= '0;
                        end
                end else if (writeEn) begin
                        regs[writeIdx] <= writeData;
                end
        end

endmodule

// File: hw/instrDecode.sv
`timescale 1ns/1ps

module instrDecode
        import immCpuPkg::*;
(
        input  logic      Clock,
        input  logic      arstN,
        input  logic      instrValid,
        input  instrT     instr,
        input  logic      issueOk,
        output logic      instrPop,
        output regIdxT    readIdx,
        input  wordT      readData,
        input  fwdT       fwdExec,
        input  fwdT       fwdWb,
        output decodedOpT decoded
);

        wordT cExt;
        wordT regB;
        wordT opB;
        logic illegal;
        logic hitExec;
        logic hitWb;

        assign instrPop = instrValid && issueOk;
        assign readIdx  = instr.rb;
        assign cExt     = {{($bits(wordT) - cW){instr.c[cW-1]}}, instr.c};

        always_comb begin
                case (instr.opcode)
                        ldi, addi, andi, ori: illegal = 1'b0;
                        default:              illegal = 1'b1;
                endcase
        end

        // ********************
        // Operand B select
        // ********************

        assign hitExec = fwdExec.valid && fwdExec.writesReg && (fwdExec.idx == instr.rb);
        assign hitWb   = fwdWb.valid && fwdWb.writesReg && (fwdWb.idx == instr.rb);

        always_comb begin
                if (hitExec) begin
                        regB = fwdExec.value;                   // Op one ahead
                end else if (hitWb) begin
                        regB = fwdWb.value;                     // Op being written back
                end else begin
                        regB = readData;
                end
        end

        // ldi treats rb = R0 as a zero base
        assign opB = ((instr.opcode == ldi) && (instr.rb == '0)) ? '0 : regB;

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        decoded <= '0;
                end else begin
                        decoded.valid <= instrPop;
                        if (instrPop) begin
                                decoded.opcode  <= instr.opcode;
                                decoded.ra      <= instr.ra;
                                decoded.opB     <= opB;
                                decoded.cExt    <= cExt;
                                decoded.illegal <= illegal;
                        end
                end
        end

endmodule

// File: hw/aluExecute.sv
`timescale 1ns/1ps

module aluExecute
        import immCpuPkg::*;
(
        input  logic      Clock,
        input  logic      arstN,
        input  decodedOpT decoded,
        output fwdT       fwdExec,
        output fwdT       execOut,
        output logic      execIllegal
);

        wordT result;

        // ********************
        // ALU
        // ********************

        always_comb begin
                case (decoded.opcode)
                        ldi, addi: result = decoded.opB + decoded.cExt;        // Wraps mod 2^32
                        andi:      result = decoded.opB & decoded.cExt;
                        ori:       result = decoded.opB | decoded.cExt;
                        default:   result = '0;                                // Illegal gives zero
                endcase
        end

        // Visible to decode in the same cycle
        always_comb begin
                fwdExec.valid     = decoded.valid;
                fwdExec.writesReg = !decoded.illegal;
                fwdExec.idx       = decoded.ra;
                fwdExec.value     = result;
        end

        // ********************
        // Execute register
        // ********************

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        execOut     <= '0;
                        execIllegal <= 1'b0;
                end else begin
                        execOut     <= fwdExec;
                        execIllegal <= decoded.valid && decoded.illegal;
                end
        end

endmodule

// File: hw/resultStage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module resultStage
        import immCpuPkg::*;
(
        input  logic   Clock,
        input  logic   arstN,
        input  fwdT    execOut,
        input  logic   execIllegal,
        input  logic   decodeBusy,
        output logic   issueOk,
        output logic   writeEn,
        output regIdxT writeIdx,
        output wordT   writeData,
        input  logic   creditIn,
        output logic   outValid,
        output resultT outResult
);

        localparam int freeW   = $clog2(`CPU_RESULT_DEPTH + 1);
        localparam int creditW = 16;

        resultT             queued;
        logic               queueValid;
        logic [freeW-1:0]   freeCount;
        logic [freeW-1:0]   inFlight;
        logic [creditW-1:0] credits;
        logic               haveCredit;

        // ********************
        // Write-back
        // ********************

        assign writeEn   = execOut.valid && execOut.writesReg;  // Illegal ops never write
        assign writeIdx  = execOut.idx;
        assign writeData = execOut.value;

        assign queued = '{dest: execOut.idx, value: execOut.value, illegal: execIllegal};

        creditFifo #(
                .payloadT(resultT),
                .depth(`CPU_RESULT_DEPTH)
        ) u_resultFifo (
                .Clock(Clock),
                .arstN(arstN),
                .pushValid(execOut.valid),
                .pushData(queued),
                .popReady(haveCredit),
                .popValid(queueValid),
                .popData(outResult),
                .creditReturn(),
                .freeCount(freeCount)
        );

        // ********************
        // Downstream credits
        // ********************

        assign haveCredit = (credits != '0);
        assign outValid   = queueValid && haveCredit;

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        credits <= '0;
                end else begin
                        credits <= credits + creditW'(creditIn) - creditW'(outValid);
                end
        end

        // Room for every op already past the input FIFO plus the new one
        assign inFlight = freeW'(decodeBusy) + freeW'(execOut.valid);
        assign issueOk  = (freeCount > inFlight);

endmodule

// File: hw/immDatapath.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module immDatapath
        import immCpuPkg::*;
(
        input  logic   Clock,
        input  logic   arstN,
        input  logic   inValid,
        input  instrT  inInstr,
        output logic   creditOut,
        output logic   outValid,
        output resultT outResult,
        input  logic   creditIn
);

        logic      headValid;
        instrT     headInstr;
        logic      instrPop;
        logic      issueOk;
        regIdxT    readIdx;
        wordT      readData;
        decodedOpT decoded;
        fwdT       fwdExec;
        fwdT       execOut;
        logic      execIllegal;
        logic      writeEn;
        regIdxT    writeIdx;
        wordT      writeData;

        // ********************
        // Front end
        // ********************

        creditFifo #(
                .payloadT(instrT),
                .depth(`CPU_INSTR_DEPTH)
        ) u_instrFifo (
                .Clock(Clock),
                .arstN(arstN),
                .pushValid(inValid),
                .pushData(inInstr),
                .popReady(instrPop),
                .popValid(headValid),
                .popData(headInstr),
                .creditReturn(creditOut),
                .freeCount()
        );

        instrDecode u_instrDecode (
                .Clock(Clock),
                .arstN(arstN),
                .instrValid(headValid),
                .instr(headInstr),
                .issueOk(issueOk),
                .instrPop(instrPop),
                .readIdx(readIdx),
                .readData(readData),
                .fwdExec(fwdExec),
                .fwdWb(execOut),                                // Write-back forward
                .decoded(decoded)
        );

        regFile u_regFile (
                .Clock(Clock),
                .arstN(arstN),
                .readIdx(readIdx),
                .readData(readData),
                .writeEn(writeEn),
                .writeIdx(writeIdx),
                .writeData(writeData)
        );

        // ********************
        // Back end
        // ********************

        aluExecute u_aluExecute (
                .Clock(Clock),
                .arstN(arstN),
                .decoded(decoded),
                .fwdExec(fwdExec),
                .execOut(execOut),
                .execIllegal(execIllegal)
        );

        resultStage u_resultStage (
                .Clock(Clock),
                .arstN(arstN),
                .execOut(execOut),
                .execIllegal(execIllegal),
                .decodeBusy(decoded.valid),
                .issueOk(issueOk),
                .writeEn(writeEn),
                .writeIdx(writeIdx),
                .writeData(writeData),
                .creditIn(creditIn),
                .outValid(outValid),
                .outResult(outResult)
        );

endmodule

// File: verif/immDatapathTb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module immDatapathTb
        import immCpuPkg::*;
();

        localparam int         halfPeriod     = 50;        // 100 ns clock
        localparam int         withholdCycles = 40;        // No downstream credits at first
        localparam int         cyclesPerTest  = 40;
        localparam logic [4:0] opLdi          = 5'd5;
        localparam logic [4:0] opAddi         = 5'd6;
        localparam logic [4:0] opAndi         = 5'd7;
        localparam logic [4:0] opOri          = 5'd8;

        logic   Clock;
        logic   arstN;
        logic   inValid;
        instrT  inInstr;
        logic   creditOut;
        logic   outValid;
        resultT outResult;
        logic   creditIn;

        string       names [$];
        logic [31:0] words [$];
        bit          kinds [$];                            // 1 marks an illegal opcode
        resultT      expQ [$];
        logic [31:0] regModel [`CPU_NUM_REGS];
        resultT      expected;
        logic [31:0] lcgState;
        int          sendCredits;
        int          sent           = 0;
        int          creditPulses   = 0;
        int          received       = 0;
        int          granted        = 0;
        int          valueErrors    = 0;
        int          protocolErrors = 0;
        bit          tableBuilt     = 1'b0;
        bit          runDone        = 1'b0;

        immDatapath u_immDatapath (
                .Clock(Clock),
                .arstN(arstN),
                .inValid(inValid),
                .inInstr(inInstr),
                .creditOut(creditOut),
                .outValid(outValid),
                .outResult(outResult),
                .creditIn(creditIn)
        );

        always #halfPeriod Clock = ~Clock;

        // ********************
        // Helpers
        // ********************

        function automatic logic [31:0] encodeInstr(input logic [4:0] op, input int ra,
                                                    input int rb, input logic [18:0] c);
                return {op, 4'(ra), 4'(rb), c};
        endfunction

        function automatic logic [31:0] nextRandom(input logic [31:0] state);
                return state * 32'd1664525 + 32'd1013904223;
        endfunction

        task automatic addTest(input string name, input logic [31:0] word, input bit isIllegal);
                names.push_back(name);
                words.push_back(word);
                kinds.push_back(isIllegal);
        endtask

        // Reference register model, applied in program order
        task automatic predictResult(input logic [31:0] word, input bit isIllegal,
                                     output resultT res);
                logic [4:0]  op;
                logic [3:0]  ra;
                logic [3:0]  rb;
                logic [31:0] c;
                logic [31:0] b;
                logic [31:0] value;
                op          = word[31:27];
                ra          = word[26:23];
                rb          = word[22:19];
                c           = {{13{word[18]}}, word[18:0]};
                res.dest    = ra;
                res.illegal = isIllegal;
                if (isIllegal) begin
                        res.value = '0;                    // Register left alone
                end else begin
                        b = ((op == opLdi) && (rb == 4'd0)) ? 32'd0 : regModel[rb];
                        case (op)
                                opAndi:  value = b & c;
                                opOri:   value = b | c;
                                default: value = b + c;    // ldi and addi
                        endcase
                        regModel[ra] = value;
                        res.value    = value;
                end
        endtask

        task automatic checkResult(input string name, input resultT exp, input resultT act);
                if (act.value !== exp.value) begin
                        $display("ERR %s value: expected %h actual %h", name, exp.value, act.value);
                        valueErrors++;
                end
                if (act.dest !== exp.dest) begin
                        $display("ERR %s dest: expected %0d actual %0d", name, exp.dest, act.dest);
                        valueErrors++;
                end
                if (act.illegal !== exp.illegal) begin
                        $display("ERR %s illegal: expected %b actual %b", name, exp.illegal,
                                 act.illegal);
                        valueErrors++;
                end
        endtask

        // ********************
        // Main sequence
        // ********************

        initial begin
                Clock   = 1'b0;
                arstN   = 1'b0;
                inValid = 1'b0;
                inInstr = '0;
                // First four issue back to back before any downstream credit
                addTest("ldiAllOnes",  encodeInstr(opLdi, 5, 0, 19'h7ffff), 1'b0);
                addTest("ldiPos",      encodeInstr(opLdi, 1, 0, 19'h01234), 1'b0);
                addTest("addiWrap",    encodeInstr(opAddi, 5, 5, 19'h00001), 1'b0);
                addTest("addiDep1",    encodeInstr(opAddi, 6, 5, 19'h7ffff), 1'b0);
                addTest("ldiNeg",      encodeInstr(opLdi, 2, 0, 19'h7fffb), 1'b0);
                addTest("ldiMaxPos",   encodeInstr(opLdi, 3, 0, 19'h3ffff), 1'b0);
                addTest("ldiBase",     encodeInstr(opLdi, 4, 1, 19'h00010), 1'b0);
                addTest("andiPos",     encodeInstr(opAndi, 7, 2, 19'h0f0f0), 1'b0);
                addTest("addiDep2",    encodeInstr(opAddi, 8, 6, 19'h00003), 1'b0);
                addTest("oriNeg",      encodeInstr(opOri, 9, 1, 19'h40000), 1'b0);
                addTest("andiNeg",     encodeInstr(opAndi, 10, 9, 19'h7ff00), 1'b0);
                addTest("ldiR0Write",  encodeInstr(opLdi, 0, 0, 19'h00055), 1'b0);
                addTest("addiR0",      encodeInstr(opAddi, 11, 0, 19'h00001), 1'b0);
                addTest("ldiR0Base",   encodeInstr(opLdi, 12, 0, 19'h00002), 1'b0);
                addTest("illegalOp",   encodeInstr(5'h1f, 3, 3, 19'h00007), 1'b1);
                addTest("illegalChk",  encodeInstr(opAddi, 13, 3, 19'h00000), 1'b0);
                addTest("illegalZero", encodeInstr(5'h00, 13, 0, 19'h00001), 1'b1);
                addTest("illegalChk2", encodeInstr(opOri, 14, 13, 19'h00000), 1'b0);
                addTest("addiLarge",   encodeInstr(opAddi, 15, 10, 19'h3ffff), 1'b0);
                for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                        regModel[i] = '0;
                end
                for (int i = 0; i < names.size(); i++) begin
                        predictResult(words[i], kinds[i], expected);
                        expQ.push_back(expected);
                end
                tableBuilt = 1'b1;

                repeat (4) @(posedge Clock);
                #1 arstN = 1'b1;

                // Sender side: one credit per valid cycle, creditOut gives one back
                sendCredits = `CPU_INSTR_DEPTH;
                while (sent < names.size()) begin
                        @(posedge Clock);
                        #1;
                        if (creditOut) begin
                                sendCredits++;
                        end
                        if (sendCredits > 0) begin
                                inValid = 1'b1;
                                inInstr = instrT'(words[sent]);
                                sendCredits--;
                                sent++;
                        end else begin
                                inValid = 1'b0;
                        end
                end
                @(posedge Clock);
                #1 inValid = 1'b0;

                wait (received == names.size());
                repeat (5) @(posedge Clock);               // Room for a stray extra result
                runDone = 1'b1;
                if (creditPulses != sent) begin
                        $display("creditOut pulsed %0d times for %0d instructions sent",
                                 creditPulses, sent);
                        protocolErrors++;
                end
                $display("Error counts: %0d value, %0d protocol", valueErrors, protocolErrors);
                if ((valueErrors == 0) && (protocolErrors == 0)) begin
                        $display("Simulation finished: PASS");
                end else begin
                        $display("Simulation finished: FAIL");
                end
                $finish;
        end

        // ********************
        // Downstream credits
        // ********************

        initial begin
                creditIn = 1'b0;
                lcgState = 32'hd0c7;
                wait (arstN === 1'b1);
                repeat (withholdCycles) @(posedge Clock);
                while (!runDone) begin
                        @(posedge Clock);
                        if (creditIn) begin
                                granted++;                 // DUT takes it at this edge
                        end
                        #1;
                        lcgState = nextRandom(lcgState);
                        creditIn = lcgState[16];
                end
        end

        // Outputs are stable mid-cycle
        always @(negedge Clock) begin
                if (arstN === 1'b1) begin
                        if (creditOut) begin
                                creditPulses++;
                                if (creditPulses > sent) begin
                                        $display("creditOut returned more credits than %0d sent",
                                                 sent);
                                        protocolErrors++;
                                end
                        end
                        if (outValid) begin
                                if (received >= granted) begin
                                        $display("outValid raised with no downstream credit held");
                                        protocolErrors++;
                                end
                                if (expQ.size() == 0) begin
                                        $display("Extra result seen: dest %0d value %h",
                                                 outResult.dest, outResult.value);
                                        protocolErrors++;
                                end else begin
                                        expected = expQ.pop_front();
                                        checkResult(names[received], expected, outResult);
                                end
                                received++;
                        end
                end
        end

        initial begin
                wait (tableBuilt);
                repeat (names.size() * cyclesPerTest) @(posedge Clock);
                $display("Timeout: only %0d of %0d results arrived", received, names.size());
                $display("Error counts: %0d value, %0d protocol", valueErrors, protocolErrors);
                $display("Simulation finished: FAIL");
                $finish;
        end

endmodule

// File: flist.f
+incdir+hw
hw/immCpuPkg.sv
hw/creditFifo.sv
hw/regFile.sv
hw/instrDecode.sv
hw/aluExecute.sv
hw/resultStage.sv
hw/immDatapath.sv
verif/immDatapathTb.sv

// File: Makefile
# Verilator build and run for the immediate-instruction datapath

VERILATOR ?= verilator
TOP       ?= immDatapathTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Test passed"; \
	else \
		echo "Test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
